// ==== logic/fod_consts.svh ====
`ifndef FOD_CONSTS_SVH
`define FOD_CONSTS_SVH

// control word split, integer and fraction bits
`define FOD_WI 6
`define FOD_WF 16

// phase compare resolution
`define FOD_WP 24
`define FOD_PHE_W 3

// divider runs at twice the aux loop rate
`define FOD_OS_SHIFT 1

// phase sync
`define FOD_PSYNC_STEP 16
`define FOD_MMD_RESET 4

// dtc gain, 8 fraction bits, init 390.0
`define FOD_KDTC_W 18
`define FOD_KDTC_FB 8
`define FOD_KDTC_INIT 18'd99840
`define FOD_LMS_SHIFT 16
`define FOD_DTC_W 10

// enabled cycles before calibration
`define FOD_SETTLE 64

`endif

// ==== logic/fod_pkg.sv ====
`include "fod_consts.svh"

package fod_pkg;

	// ------------------------------
	// fixed-point words
	// ------------------------------

	// full fcw, unsigned WI.WF
	typedef logic [`FOD_WI+`FOD_WF-1:0] fcw_t;

	// fraction of fcw, also dsm residual phase
	typedef logic [`FOD_WF-1:0] frac_t;

	// integer part, mmd ratio
	typedef logic [`FOD_WI-1:0] int_t;

	// signed phase difference, one turn = 2^WP
	typedef logic signed [`FOD_WP-1:0] phase_t;

	// measured phase code, top bits of a turn
	typedef logic [`FOD_PHE_W-1:0] phe_code_t;

	// dtc gain, unsigned with KDTC_FB fraction bits
	typedef logic [`FOD_KDTC_W-1:0] kdtc_t;

	// dtc control code
	typedef logic [`FOD_DTC_W-1:0] dtc_word_t;

endpackage

// ==== logic/dsm_if.sv ====
interface dsm_if import fod_pkg::*; ();

	// fraction fed into the accumulator
	frac_t frac;
	// accumulator advance enable
	logic step;
	// overflow of the accumulator
	logic carry;
	// residual phase after the add
	frac_t phase;

	// accumulator side
	modport acc (
		input  frac,
		input  step,
		output carry,
		output phase
	);

	// consumers of carry and phase, nco also supplies frac
	modport user (
		input  carry,
		input  phase,
		input  step,
		output frac
	);

endinterface

// ==== logic/fod_seq.sv ====
`include "fod_consts.svh"

module fod_seq (
	input  logic clk,
	input  logic nrst,
	input  logic dsm_en,
	input  logic cal_en,
	output logic step,
	output logic psync_en,
	output logic lms_en
);

	localparam int CNT_W = $clog2(`FOD_SETTLE + 1);

	logic [CNT_W-1:0] settle_cnt;
	logic settled;
	logic cal_run;

	// dsm advances whenever the divider path is on
	assign step = dsm_en;

	// ------------------------------
	// settle counter
	// ------------------------------

	// counts cycles with both enables high
	// any gap restarts the wait
	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			settle_cnt <= '0;
		end else if (!dsm_en || !cal_en) begin
			settle_cnt <= '0;
		end else if (!settled) begin
			settle_cnt <= settle_cnt + 1'b1;
		end
	end

	// saturates here
	assign settled = (settle_cnt == CNT_W'(`FOD_SETTLE));

	// ------------------------------
	// calibration release
	// ------------------------------

	// drops in the same cycle as cal_en
	assign cal_run = settled && cal_en && dsm_en;

	// phase sync and gain loop start together
	assign psync_en = cal_run;
	assign lms_en = cal_run;

endmodule

// ==== logic/fcw_mash1.sv ====
`include "fod_consts.svh"

module fcw_mash1 import fod_pkg::*; (
	input  logic clk,
	input  logic nrst,
	dsm_if.acc   dsm,
	input  int_t fcw_int,
	output int_t mmd_dcw,
	output logic rt_dcw
);

	logic [`FOD_WF:0] sum;
	frac_t acc_q;
	logic carry_q;
	int_t int_sync;

	// ------------------------------
	// first order accumulator
	// ------------------------------

	// extra msb catches the wrap
	assign sum = {1'b0, acc_q} + {1'b0, dsm.frac};

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			acc_q <= '0;
			carry_q <= 1'b0;
		end else if (dsm.step) begin
			acc_q <= sum[`FOD_WF-1:0];
			carry_q <= sum[`FOD_WF];
		end
	end

	assign dsm.carry = carry_q;
	assign dsm.phase = acc_q;

	// integer part, same edge as carry
	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			int_sync <= int_t'(`FOD_MMD_RESET);
		end else if (dsm.step) begin
			int_sync <= fcw_int;
		end
	end

	// ------------------------------
	// divider and retimer words
	// ------------------------------

	// mmd = int + carry, retimer picks half cycle from phase msb
	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			mmd_dcw <= int_t'(`FOD_MMD_RESET);
			rt_dcw <= 1'b0;
		end else if (dsm.step) begin
			mmd_dcw <= int_sync + int_t'(carry_q);
			rt_dcw <= acc_q[`FOD_WF-1];
		end
	end

endmodule

// ==== logic/phase_sync_nco.sv ====
`include "fod_consts.svh"

module phase_sync_nco import fod_pkg::*; (
	input  logic      clk,
	input  logic      nrst,
	input  logic      psync_en,
	input  fcw_t      fcw_fod,
	input  phe_code_t phe_meas,
	dsm_if.user       dsm,
	output int_t      fcw_int,
	output frac_t     phe_norm
);

	localparam int NCO_W = `FOD_WF + `FOD_OS_SHIFT;
	// phase lsb to fcw lsb
	localparam int CAL_SH = `FOD_WP - `FOD_WI - `FOD_WF;

	logic [NCO_W-1:0] nco_q;
	logic [NCO_W-1:0] nco_next;
	phase_t nco_s;
	phase_t meas_s;
	phase_t diff;
	phase_t step_sel;
	phase_t corr_q;
	fcw_t fcw_adj;

	// ------------------------------
	// nco at divider rate
	// ------------------------------

	// only low WF+OS bits matter, wraps mod 2^NCO_W
	assign nco_next = nco_q + fcw_fod[NCO_W-1:0];

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			nco_q <= '0;
		end else if (dsm.step) begin
			nco_q <= nco_next;
		end
	end

	// ------------------------------
	// phase compare
	// ------------------------------

	// both scaled to one turn = 2^WP
	assign nco_s = {nco_next, {(`FOD_WP-NCO_W){1'b0}}};
	assign meas_s = {phe_meas, {(`FOD_WP-`FOD_PHE_W){1'b0}}};
	assign diff = nco_s - meas_s;

	// bang-bang, sign only
	assign step_sel = !psync_en ? '0 :
		diff[`FOD_WP-1] ? -phase_t'(`FOD_PSYNC_STEP) : phase_t'(`FOD_PSYNC_STEP);

	// correction applied on the following cycle
	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			corr_q <= '0;
		end else begin
			corr_q <= step_sel;
		end
	end

	// sign kept through the shift
	assign fcw_adj = fcw_fod + fcw_t'(corr_q >>> CAL_SH);
	assign fcw_int = fcw_adj[`FOD_WI+`FOD_WF-1:`FOD_WF];
	assign dsm.frac = fcw_adj[`FOD_WF-1:0];

	// round half up to WF bits
	assign phe_norm = diff[`FOD_WP-1 -: `FOD_WF] + frac_t'(diff[`FOD_WP-`FOD_WF-1]);

endmodule

// ==== logic/dtc_lms_cal.sv ====
`include "fod_consts.svh"

module dtc_lms_cal import fod_pkg::*; (
	input  logic      clk,
	input  logic      nrst,
	input  logic      lms_en,
	dsm_if.user       dsm,
	input  frac_t     phe_norm,
	output dtc_word_t dtc_dcw
);

	localparam int PROD_W = `FOD_WF + `FOD_KDTC_W;
	// product lsb to dtc lsb
	localparam int DTC_SH = `FOD_WF + `FOD_KDTC_FB;
	// two guard bits for sign and overflow
	localparam int GSUM_W = `FOD_KDTC_W + 2;

	frac_t rem;
	frac_t rem_d1;
	frac_t rem_d2;
	kdtc_t kdtc_q;
	logic signed [2*`FOD_WF:0] corr;
	logic signed [GSUM_W-1:0] kdtc_sum;
	logic [PROD_W-1:0] dtc_raw;
	logic [PROD_W:0] dtc_rnd;
	logic dtc_sat;

	// remainder below the half cycle, times two, 0 to 1
	assign rem = {dsm.phase[`FOD_WF-2:0], 1'b0};

	// ------------------------------
	// lms gain loop
	// ------------------------------

	// two steps back, lines up with phe_norm
	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			rem_d1 <= '0;
			rem_d2 <= '0;
		end else if (dsm.step) begin
			rem_d1 <= rem;
			rem_d2 <= rem_d1;
		end
	end

	// error times delayed remainder
	assign corr = $signed(phe_norm) * $signed({1'b0, rem_d2});
	assign kdtc_sum = $signed({2'b00, kdtc_q}) + GSUM_W'(corr >>> `FOD_LMS_SHIFT);

	// clamp to the unsigned gain range
	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			kdtc_q <= `FOD_KDTC_INIT;
		end else if (lms_en && dsm.step) begin
			if (kdtc_sum[GSUM_W-1]) begin
				kdtc_q <= '0;
			end else if (kdtc_sum[GSUM_W-2]) begin
				kdtc_q <= '1;
			end else begin
				kdtc_q <= kdtc_sum[`FOD_KDTC_W-1:0];
			end
		end
	end

	// ------------------------------
	// dtc word
	// ------------------------------

	assign dtc_raw = rem * kdtc_q;
	// round at the dtc lsb
	assign dtc_rnd = dtc_raw + ((PROD_W+1)'(1) << (DTC_SH - 1));
	assign dtc_sat = |dtc_rnd[PROD_W:DTC_SH+`FOD_DTC_W];

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			dtc_dcw <= '0;
		end else if (dsm.step) begin
			dtc_dcw <= dtc_sat ? '1 : dtc_rnd[DTC_SH +: `FOD_DTC_W];
		end
	end

endmodule

// ==== logic/fod_ctrl_top.sv ====
module fod_ctrl_top import fod_pkg::*; (
	input  logic      clk,
	input  logic      nrst,
	input  logic      dsm_en,
	input  logic      cal_en,
	input  fcw_t      fcw_fod,
	input  phe_code_t phe_meas,
	output int_t      mmd_dcw,
	output logic      rt_dcw,
	output dtc_word_t dtc_dcw
);

	logic psync_en;
	logic lms_en;
	int_t fcw_int;
	frac_t phe_norm;

	// accumulator link
	dsm_if dsm ();

	// enables and settle wait
	fod_seq fod_seq_i (
		.clk      (clk),
		.nrst     (nrst),
		.dsm_en   (dsm_en),
		.cal_en   (cal_en),
		.step     (dsm.step),
		.psync_en (psync_en),
		.lms_en   (lms_en)
	);

	// fcw correction and split, phase error
	phase_sync_nco phase_sync_nco_i (
		.clk      (clk),
		.nrst     (nrst),
		.psync_en (psync_en),
		.fcw_fod  (fcw_fod),
		.phe_meas (phe_meas),
		.dsm      (dsm),
		.fcw_int  (fcw_int),
		.phe_norm (phe_norm)
	);

	// dsm, mmd and retimer words
	fcw_mash1 fcw_mash1_i (
		.clk     (clk),
		.nrst    (nrst),
		.dsm     (dsm),
		.fcw_int (fcw_int),
		.mmd_dcw (mmd_dcw),
		.rt_dcw  (rt_dcw)
	);

	// dtc word with gain calibration
	dtc_lms_cal dtc_lms_cal_i (
		.clk      (clk),
		.nrst     (nrst),
		.lms_en   (lms_en),
		.dsm      (dsm),
		.phe_norm (phe_norm),
		.dtc_dcw  (dtc_dcw)
	);

endmodule

// ==== sim/fod_ctrl_tb.sv ====
`include "fod_consts.svh"

module fod_ctrl_tb import fod_pkg::*; ;
	timeunit 1ns;
	timeprecision 1ps;

	// one table row, applied for a number of cycles
	typedef struct packed {
		fcw_t fcw;
		phe_code_t phe;
		logic den;
		logic cen;
		logic [15:0] cycles;
		int_t exp_int;
	} row_t;

	logic clk;
	logic nrst;
	logic dsm_en;
	logic cal_en;
	fcw_t fcw_fod;
	phe_code_t phe_meas;
	int_t mmd_dcw;
	logic rt_dcw;
	dtc_word_t dtc_dcw;

	row_t rows[$];
	string names[$];
	// reference model state
	longint unsigned m_acc;
	longint unsigned m_gain;
	int m_carry, m_sync, m_mmd, m_rt, m_dtc;
	fcw_t m_fcw;
	logic m_den, m_cen;
	int cal_cycles;
	int errors, checks;

	fod_ctrl_top fod_ctrl_top_i (
		.clk (clk), .nrst (nrst), .dsm_en (dsm_en), .cal_en (cal_en),
		.fcw_fod (fcw_fod), .phe_meas (phe_meas),
		.mmd_dcw (mmd_dcw), .rt_dcw (rt_dcw), .dtc_dcw (dtc_dcw)
	);

	always #4 clk = ~clk;

	task automatic check_value(string name, longint exp, longint act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_mmd_range(int lo, int hi);
		checks++;
		if (int'(mmd_dcw) < lo || int'(mmd_dcw) > hi) begin
			errors++;
			$display("mmd_dcw %0d left the range %0d to %0d at %0t", mmd_dcw, lo, hi, $time);
		end
	endtask

	task automatic add_row(string name, fcw_t fcw, phe_code_t phe, logic den, logic cen,
			int cycles, int_t exp_int);
		rows.push_back({fcw, phe, den, cen, 16'(cycles), exp_int});
		names.push_back(name);
	endtask

	// ------------------------------
	// reference model, one edge
	// ------------------------------

	task automatic model_edge();
		longint unsigned rem;
		longint unsigned p;
		longint unsigned sum;
		if (m_den) begin
			// remainder below half cycle, times two
			rem = (m_acc % 32768) * 2;
			p = (rem * m_gain + (64'd1 << 23)) >> 24;
			m_dtc = (p > 1023) ? 1023 : int'(p);
			m_mmd = (m_sync + m_carry) % 64;
			m_rt = int'(m_acc >> 15);
			sum = m_acc + longint'(m_fcw[15:0]);
			m_carry = int'(sum >> 16);
			m_acc = sum % 65536;
			m_sync = int'(m_fcw[21:16]);
		end
	endtask

	task automatic run_row(int idx);
		row_t r;
		int start_err;
		r = rows[idx];
		start_err = errors;
		for (int i = 0; i < int'(r.cycles); i++) begin
			@(posedge clk);
			// the dut just consumed the previous inputs
			model_edge();
			cal_cycles = (m_den && m_cen) ? cal_cycles + 1 : 0;
			fcw_fod <= r.fcw;
			phe_meas <= r.phe;
			dsm_en <= r.den;
			cal_en <= r.cen;
			m_fcw = r.fcw;
			m_den = r.den;
			m_cen = r.cen;
			@(negedge clk);
			if (cal_cycles <= `FOD_SETTLE) begin
				check_value("mmd_dcw", m_mmd, mmd_dcw);
				check_value("rt_dcw", m_rt, rt_dcw);
				check_value("dtc_dcw", m_dtc, dtc_dcw);
			end else begin
				// calibration moves fcw by a few lsb only
				check_mmd_range(int'(r.exp_int) - 1, int'(r.exp_int) + 2);
				checks++;
				if ($isunknown(dtc_dcw)) begin
					errors++;
					$display("dtc_dcw went unknown during calibration at %0t", $time);
				end
			end
		end
		if (!r.cen)
			check_mmd_range(int'(r.exp_int), int'(r.exp_int) + 1);
		$display("test %0d %s finished, %0d errors", idx + 1, names[idx], errors - start_err);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		int_t ri;
		void'($urandom(32'h96375694));
		clk = 1'b0;
		nrst = 1'b0;
		dsm_en = 1'b0;
		cal_en = 1'b0;
		fcw_fod = '0;
		phe_meas = '0;
		errors = 0;
		checks = 0;
		cal_cycles = 0;
		m_acc = 0;
		m_gain = 390 * 256;
		m_carry = 0;
		m_sync = 4;
		m_mmd = 4;
		m_rt = 0;
		m_dtc = 0;
		m_fcw = '0;
		m_den = 1'b0;
		m_cen = 1'b0;

		add_row("integer fcw", {6'd8, 16'h0000}, 3'd0, 1'b1, 1'b0, 20, 6'd8);
		add_row("quarter fraction", {6'd10, 16'h4000}, 3'd0, 1'b1, 1'b0, 40, 6'd10);
		add_row("odd fraction", {6'd5, 16'hB333}, 3'd0, 1'b1, 1'b0, 40, 6'd5);
		add_row("hold", {6'd12, 16'h8000}, 3'd0, 1'b0, 1'b0, 10, 6'd5);
		add_row("resume", {6'd12, 16'h8000}, 3'd0, 1'b1, 1'b0, 30, 6'd12);
		for (int k = 0; k < 8; k++) begin
			ri = int_t'(4 + $urandom % 56);
			add_row("random fcw", {ri, 16'($urandom)}, 3'd0, 1'b1, 1'b0, 30, ri);
		end
		add_row("fraction near wrap", {6'd33, 16'hFFFF}, 3'd0, 1'b1, 1'b0, 30, 6'd33);
		add_row("settle", {6'd20, 16'h4CCD}, 3'd3, 1'b1, 1'b1, `FOD_SETTLE, 6'd20);
		add_row("calibration", {6'd20, 16'h4CCD}, 3'd3, 1'b1, 1'b1, 300, 6'd20);

		repeat (2) @(posedge clk);
		nrst <= 1'b1;
		// released, no step taken yet
		@(negedge clk);
		check_value("mmd_dcw", 4, mmd_dcw);
		check_value("rt_dcw", 0, rt_dcw);
		check_value("dtc_dcw", 0, dtc_dcw);
		$display("test 0 reset values finished, %0d errors", errors);

		for (int i = 0; i < rows.size(); i++)
			run_row(i);

		$display("tests %0d checks %0d errors %0d", rows.size() + 1, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// watchdog for the whole run
	initial begin
		#20000;
		$display("timeout, the run did not finish in time");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== fod_ctrl_top.f ====
+incdir+logic
logic/fod_pkg.sv
logic/dsm_if.sv
logic/fod_seq.sv
logic/fcw_mash1.sv
logic/phase_sync_nco.sv
logic/dtc_lms_cal.sv
logic/fod_ctrl_top.sv
sim/fod_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --timing -Wno-fatal -j 0
TOP       = fod_ctrl_tb
FILELIST  = fod_ctrl_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
BIN       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
